/* src/decode_pkg.sv */
// Field decoder shared definitions
`default_nettype none

package decode_pkg;

    localparam int INSN_BYTE_W    = 8;
    localparam int MAX_INSN_BYTES = 3;  // opcode and modrm bytes only.

    typedef logic [INSN_BYTE_W-1:0] insn_byte_t;
    typedef logic [1:0]             byte_idx_t;
    typedef logic [2:0]             gpr_t;
    typedef logic [2:0]             sreg3_t;
    typedef logic [1:0]             sreg2_t;
    typedef logic [1:0]             mod_t;
    typedef logic [2:0]             rm_t;

    localparam insn_byte_t ESCAPE_OPCODE = 8'h0F;

    typedef enum logic [3:0] {
        OP_MOV,
        OP_MOV_SREG,
        OP_MOV_IMM,
        OP_PUSH,
        OP_POP,
        OP_INC,
        OP_DEC,
        OP_PUSH_SREG,
        OP_POP_SREG,
        OP_ALU,
        OP_ALU_IMM,
        OP_MOVX,
        OP_ILLEGAL
    } op_class_e;

    typedef enum logic [1:0] {W_NONE, W_B0_BIT0, W_B0_BIT3, W_B1_BIT0} w_loc_e;
    typedef enum logic [1:0] {REG_NONE, REG_B0_LOW, REG_B1_MID, REG_B2_MID} reg_loc_e;
    typedef enum logic [1:0] {SREG_NONE, SREG2_B0, SREG3_B1} sreg_loc_e;
    typedef enum logic [1:0] {MODRM_NONE, MODRM_B1, MODRM_B2} modrm_loc_e;

    // encoding matches the byte position.
    typedef enum logic [1:0] {
        ST_BYTE0 = 2'd0,
        ST_BYTE1 = 2'd1,
        ST_BYTE2 = 2'd2
    } seq_state_e;

endpackage

`default_nettype wire

/* src/insn_if.sv */
// Collected instruction bytes
`timescale 1ns/1ps
`default_nettype none

interface insn_if import decode_pkg::*; ();

    insn_byte_t byte0;  // opcode or escape.
    insn_byte_t byte1;
    insn_byte_t byte2;

    modport buffer (output byte0, byte1, byte2);
    modport user   (input  byte0, byte1, byte2);

endinterface

`default_nettype wire

/* src/decode_if.sv */
// Opcode classification bus
`timescale 1ns/1ps
`default_nettype none

interface decode_if import decode_pkg::*; ();

    op_class_e  op_class;
    byte_idx_t  insn_len;   // 1 to 3.
    w_loc_e     w_loc;
    reg_loc_e   reg_loc;
    sreg_loc_e  sreg_loc;
    modrm_loc_e modrm_loc;

    modport cls (output op_class, insn_len, w_loc, reg_loc, sreg_loc, modrm_loc);
    modport seq (input  insn_len);
    modport ext (input  op_class, w_loc, reg_loc, sreg_loc, modrm_loc);

endinterface

`default_nettype wire

/* src/insn_buffer.sv */
// Instruction byte buffer
`timescale 1ns/1ps
`default_nettype none

module insn_buffer import decode_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       wr_en,
    input  byte_idx_t  wr_idx,
    input  insn_byte_t byte_data,
    insn_if.buffer     bytes
);

    insn_byte_t                stored [MAX_INSN_BYTES];
    insn_byte_t                view   [MAX_INSN_BYTES];
    logic [MAX_INSN_BYTES-1:0] hit;

    for (genvar i = 0; i < MAX_INSN_BYTES; i++) begin : g_slot
        assign hit[i]  = wr_en && (wr_idx == byte_idx_t'(i));
        assign view[i] = hit[i] ? byte_data : stored[i];  // bypass on write.
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MAX_INSN_BYTES; i++) stored[i] <= '0;
        end else begin
            for (int i = 0; i < MAX_INSN_BYTES; i++) begin
                if (hit[i]) stored[i] <= byte_data;
            end
        end
    end

    assign bytes.byte0 = view[0];
    assign bytes.byte1 = view[1];
    assign bytes.byte2 = view[2];

endmodule

`default_nettype wire

/* src/opcode_classifier.sv */
// Opcode classifier
`timescale 1ns/1ps
`default_nettype none

module opcode_classifier import decode_pkg::*; (
    insn_if.user  bytes,
    decode_if.cls dec
);

    always_comb begin
        dec.op_class  = OP_ILLEGAL;
        dec.insn_len  = 2'd1;
        dec.w_loc     = W_NONE;
        dec.reg_loc   = REG_NONE;
        dec.sreg_loc  = SREG_NONE;
        dec.modrm_loc = MODRM_NONE;

        case (bytes.byte0) inside
            [8'h88:8'h8B]: begin
                dec.op_class  = OP_MOV;
                dec.insn_len  = 2'd2;
                dec.w_loc     = W_B0_BIT0;
                dec.reg_loc   = REG_B1_MID;
                dec.modrm_loc = MODRM_B1;
            end
            8'h8C, 8'h8E: begin
                dec.op_class  = OP_MOV_SREG;
                dec.insn_len  = 2'd2;
                dec.sreg_loc  = SREG3_B1;
                dec.modrm_loc = MODRM_B1;
            end
            [8'hB0:8'hBF]: begin
                dec.op_class = OP_MOV_IMM;
                dec.w_loc    = W_B0_BIT3;  // short form has w at bit 3.
                dec.reg_loc  = REG_B0_LOW;
            end
            [8'h50:8'h57]: begin
                dec.op_class = OP_PUSH;
                dec.reg_loc  = REG_B0_LOW;
            end
            [8'h58:8'h5F]: begin
                dec.op_class = OP_POP;
                dec.reg_loc  = REG_B0_LOW;
            end
            [8'h40:8'h47]: begin
                dec.op_class = OP_INC;
                dec.reg_loc  = REG_B0_LOW;
            end
            [8'h48:8'h4F]: begin
                dec.op_class = OP_DEC;
                dec.reg_loc  = REG_B0_LOW;
            end
            8'h06, 8'h0E, 8'h16, 8'h1E: begin
                dec.op_class = OP_PUSH_SREG;
                dec.sreg_loc = SREG2_B0;
            end
            8'h07, 8'h17, 8'h1F: begin
                dec.op_class = OP_POP_SREG;
                dec.sreg_loc = SREG2_B0;
            end
            [8'h00:8'h03], [8'h28:8'h2B], [8'h30:8'h33]: begin
                dec.op_class  = OP_ALU;
                dec.insn_len  = 2'd2;
                dec.w_loc     = W_B0_BIT0;
                dec.modrm_loc = MODRM_B1;
            end
            8'h80, 8'h81, 8'h83: begin
                dec.op_class  = OP_ALU_IMM;
                dec.insn_len  = 2'd2;
                dec.w_loc     = W_B0_BIT0;
                dec.modrm_loc = MODRM_B1;
            end
            ESCAPE_OPCODE: begin
                dec.insn_len = 2'd2;  // unknown second byte stays illegal.
                if (bytes.byte1 inside {8'hB6, 8'hB7, 8'hBE, 8'hBF}) begin
                    dec.op_class  = OP_MOVX;
                    dec.insn_len  = 2'd3;
                    dec.w_loc     = W_B1_BIT0;
                    dec.reg_loc   = REG_B2_MID;
                    dec.modrm_loc = MODRM_B2;
                end
            end
            default: ;
        endcase

        // only movzx/movsx runs to a third byte.
        a_len_valid: assert ((dec.insn_len != 2'd0)
                             && ((dec.insn_len == 2'd3) == (dec.op_class == OP_MOVX)));
    end

endmodule

`default_nettype wire

/* src/decode_sequencer.sv */
// Byte position sequencer
`timescale 1ns/1ps
`default_nettype none

module decode_sequencer import decode_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      byte_valid,
    decode_if.seq     dec,
    output logic      wr_en,
    output byte_idx_t wr_idx,
    output logic      insn_done
);

    seq_state_e state;
    seq_state_e state_next;

    assign wr_en     = byte_valid;  // no back-pressure.
    assign wr_idx    = byte_idx_t'(state);
    assign insn_done = byte_valid && (byte_idx_t'(wr_idx + 2'd1) == dec.insn_len);

    always_comb begin
        state_next = state;
        if (insn_done) begin
            state_next = ST_BYTE0;
        end else if (byte_valid) begin
            case (state)
                ST_BYTE0: state_next = ST_BYTE1;
                ST_BYTE1: state_next = ST_BYTE2;
                default:  state_next = ST_BYTE0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_BYTE0;
        end else begin
            state <= state_next;
        end
    end

    // the classifier must end every instruction by the third byte.
    a_byte2_ends: assert property (@(posedge clk) disable iff (rst)
        byte_valid && (state == ST_BYTE2) |-> insn_done);

endmodule

`default_nettype wire

/* src/field_extractor.sv */
// Instruction field extractor
`timescale 1ns/1ps
`default_nettype none

module field_extractor import decode_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      insn_done,
    insn_if.user      bytes,
    decode_if.ext     dec,
    output logic      fields_valid,
    output op_class_e op_class,
    output logic      s,
    output logic      w,
    output gpr_t      gpr,
    output sreg3_t    sreg3,
    output sreg2_t    sreg2,
    output mod_t      mod,
    output rm_t       rm
);

    logic       s_d;
    logic       w_d;
    gpr_t       gpr_d;
    insn_byte_t modrm;

    assign s_d = (dec.op_class == OP_ALU_IMM) ? bytes.byte0[1] : 1'b0;

    always_comb begin
        case (dec.w_loc)
            W_B0_BIT0: w_d = bytes.byte0[0];
            W_B0_BIT3: w_d = bytes.byte0[3];
            W_B1_BIT0: w_d = bytes.byte1[0];
            default:   w_d = 1'b0;
        endcase

        case (dec.reg_loc)
            REG_B0_LOW: gpr_d = bytes.byte0[2:0];
            REG_B1_MID: gpr_d = bytes.byte1[5:3];
            REG_B2_MID: gpr_d = bytes.byte2[5:3];
            default:    gpr_d = '0;
        endcase

        case (dec.modrm_loc)
            MODRM_B1: modrm = bytes.byte1;
            MODRM_B2: modrm = bytes.byte2;
            default:  modrm = '0;  // mod and rm read zero.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fields_valid <= 1'b0;
            op_class     <= OP_MOV;
            s            <= 1'b0;
            w            <= 1'b0;
            gpr          <= '0;
            sreg3        <= '0;
            sreg2        <= '0;
            mod          <= '0;
            rm           <= '0;
        end else begin
            fields_valid <= insn_done;
            if (insn_done) begin
                op_class <= dec.op_class;
                s        <= s_d;
                w        <= w_d;
                gpr      <= gpr_d;
                sreg3    <= (dec.sreg_loc == SREG3_B1) ? bytes.byte1[5:3] : 3'd0;
                sreg2    <= (dec.sreg_loc == SREG2_B0) ? bytes.byte0[4:3] : 2'd0;
                mod      <= modrm[7:6];
                rm       <= modrm[2:0];
            end
        end
    end

    // back-to-back results leave no room for a modrm byte.
    a_back_to_back: assert property (@(posedge clk) disable iff (rst)
        insn_done && fields_valid |-> dec.modrm_loc == MODRM_NONE);

endmodule

`default_nettype wire

/* src/decode_field_top.sv */
// Byte-serial field decoder
`timescale 1ns/1ps
`default_nettype none

module decode_field_top import decode_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       byte_valid,
    input  insn_byte_t byte_data,
    output logic       fields_valid,
    output op_class_e  op_class,
    output logic       s,
    output logic       w,
    output gpr_t       gpr,
    output sreg3_t     sreg3,
    output sreg2_t     sreg2,
    output mod_t       mod,
    output rm_t        rm
);

    logic      wr_en;
    byte_idx_t wr_idx;
    logic      insn_done;

    insn_if   insn_bus ();
    decode_if dec_bus ();

    insn_buffer u_buffer (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .byte_data (byte_data),
        .bytes     (insn_bus.buffer)
    );

    opcode_classifier u_classifier (
        .bytes (insn_bus.user),
        .dec   (dec_bus.cls)
    );

    decode_sequencer u_sequencer (
        .clk        (clk),
        .rst        (rst),
        .byte_valid (byte_valid),
        .dec        (dec_bus.seq),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .insn_done  (insn_done)
    );

    field_extractor u_extractor (
        .clk          (clk),
        .rst          (rst),
        .insn_done    (insn_done),
        .bytes        (insn_bus.user),
        .dec          (dec_bus.ext),
        .fields_valid (fields_valid),
        .op_class     (op_class),
        .s            (s),
        .w            (w),
        .gpr          (gpr),
        .sreg3        (sreg3),
        .sreg2        (sreg2),
        .mod          (mod),
        .rm           (rm)
    );

endmodule

`default_nettype wire

/* testbench/tb_decode_field.sv */
// Field decoder testbench
`timescale 1ns/1ps
`default_nettype none

module tb_decode_field import decode_pkg::*; ();

    typedef struct packed {
        op_class_e cls;
        logic      s;
        logic      w;
        gpr_t      gpr;
        sreg3_t    sreg3;
        sreg2_t    sreg2;
        mod_t      mod;
        rm_t       rm;
    } result_t;

    logic       clk, rst, byte_valid, fields_valid, s, w;
    insn_byte_t byte_data;
    op_class_e  op_class;
    gpr_t       gpr;
    sreg3_t     sreg3;
    sreg2_t     sreg2;
    mod_t       mod;
    rm_t        rm;
    result_t    expected_q [$];

    decode_field_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic result_t model_fields(input insn_byte_t b0, input insn_byte_t b1,
                                             input insn_byte_t b2);
        result_t    r;
        insn_byte_t modrm;
        r     = '0;
        r.cls = OP_ILLEGAL;
        modrm = 8'h00;
        if (b0 inside {[8'h88:8'h8B]}) begin
            r.cls = OP_MOV;
            r.w   = b0[0];
            r.gpr = b1[5:3];
            modrm = b1;
        end else if (b0 inside {8'h8C, 8'h8E}) begin
            r.cls   = OP_MOV_SREG;
            r.sreg3 = b1[5:3];
            modrm   = b1;
        end else if (b0[7:4] == 4'hB) begin
            r.cls = OP_MOV_IMM;
            r.w   = b0[3];
            r.gpr = b0[2:0];
        end else if (b0[7:5] == 3'b010) begin  // 40 to 5f.
            r.cls = b0[4] ? (b0[3] ? OP_POP : OP_PUSH) : (b0[3] ? OP_DEC : OP_INC);
            r.gpr = b0[2:0];
        end else if (b0 inside {8'h06, 8'h0E, 8'h16, 8'h1E, 8'h07, 8'h17, 8'h1F}) begin
            r.cls   = b0[0] ? OP_POP_SREG : OP_PUSH_SREG;
            r.sreg2 = b0[4:3];
        end else if (b0 inside {[8'h00:8'h03], [8'h28:8'h2B], [8'h30:8'h33]}) begin
            r.cls = OP_ALU;
            r.w   = b0[0];
            modrm = b1;
        end else if (b0 inside {8'h80, 8'h81, 8'h83}) begin
            r.cls = OP_ALU_IMM;
            r.s   = b0[1];
            r.w   = b0[0];
            modrm = b1;
        end else if (b0 == 8'h0F && b1 inside {8'hB6, 8'hB7, 8'hBE, 8'hBF}) begin
            r.cls = OP_MOVX;
            r.w   = b1[0];
            r.gpr = b2[5:3];
            modrm = b2;
        end
        r.mod = modrm[7:6];
        r.rm  = modrm[2:0];
        return r;
    endfunction

    function automatic int insn_length(input insn_byte_t b0, input insn_byte_t b1);
        if (b0 == 8'h0F) return (b1 inside {8'hB6, 8'hB7, 8'hBE, 8'hBF}) ? 3 : 2;
        return (b0 inside {[8'h88:8'h8C], 8'h8E, [8'h00:8'h03], [8'h28:8'h2B],
                           [8'h30:8'h33], 8'h80, 8'h81, 8'h83}) ? 2 : 1;
    endfunction

    task automatic check_field(input string test, input string field, input int exp_val,
                               input int act_val);
        assert (exp_val == act_val) else begin
            $display("[ERROR] %s: %s expected %0h actual %0h", test, field, exp_val, act_val);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_result(input string test, input result_t exp);
        check_field(test, "op_class", int'(exp.cls), int'(op_class));
        check_field(test, "s", int'(exp.s), int'(s));
        check_field(test, "w", int'(exp.w), int'(w));
        check_field(test, "gpr", int'(exp.gpr), int'(gpr));
        check_field(test, "sreg3", int'(exp.sreg3), int'(sreg3));
        check_field(test, "sreg2", int'(exp.sreg2), int'(sreg2));
        check_field(test, "mod", int'(exp.mod), int'(mod));
        check_field(test, "rm", int'(exp.rm), int'(rm));
    endtask

    task automatic fail_timeout(input string test);
        $display("%s: no fields_valid pulse within 20 cycles", test);
        $display("Test failed");
        $fatal(1);
    endtask

    // sends one instruction and checks pulse timing and fields.
    task automatic run_insn(input string test, input insn_byte_t b0, input insn_byte_t b1,
                            input insn_byte_t b2);
        insn_byte_t seq_bytes [3];
        int         len;
        int         cycles;
        seq_bytes = '{b0, b1, b2};
        len       = insn_length(b0, b1);
        for (int i = 0; i < len; i++) begin
            byte_valid = 1'b1;
            byte_data  = seq_bytes[i];
            @(negedge clk);
            byte_valid = 1'b0;
            if (i < len - 1) begin
                check_field(test, "fields_valid before last byte", 0, int'(fields_valid));
            end
        end
        cycles = 0;
        while (!fields_valid) begin
            if (cycles >= 20) begin
                fail_timeout(test);
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
        check_field(test, "extra latency cycles", 0, cycles);
        check_result(test, model_fields(b0, b1, b2));
        @(negedge clk);
        check_field(test, "fields_valid after pulse", 0, int'(fields_valid));
    endtask

    task automatic test_reset();
        result_t zero;
        zero = '0;
        repeat (8) begin
            @(negedge clk);
            check_field("reset", "fields_valid in reset", 0, int'(fields_valid));
        end
        rst = 1'b0;
        repeat (10) begin
            @(negedge clk);
            check_field("reset", "fields_valid idle", 0, int'(fields_valid));
        end
        check_result("reset", zero);
    endtask

    task automatic test_one_byte();
        logic [31:0] r;
        insn_byte_t  sreg_ops [7];
        sreg_ops = '{8'h06, 8'h0E, 8'h16, 8'h1E, 8'h07, 8'h17, 8'h1F};
        for (int i = 0; i < 8; i++) begin
            r = $urandom;
            run_insn("mov_imm", {4'hB, r[3:0]}, 8'h00, 8'h00);
            run_insn("push", {5'b01010, r[6:4]}, 8'h00, 8'h00);
            run_insn("pop", {5'b01011, r[9:7]}, 8'h00, 8'h00);
            run_insn("inc", {5'b01000, r[12:10]}, 8'h00, 8'h00);
            run_insn("dec", {5'b01001, r[15:13]}, 8'h00, 8'h00);
        end
        foreach (sreg_ops[i]) run_insn("sreg_push_pop", sreg_ops[i], 8'h00, 8'h00);
    endtask

    task automatic test_modrm();
        logic [31:0] r;
        insn_byte_t  alu_base [3];
        insn_byte_t  imm_ops [3];
        alu_base = '{8'h00, 8'h28, 8'h30};
        imm_ops  = '{8'h80, 8'h81, 8'h83};
        for (int i = 0; i < 12; i++) begin
            r = $urandom;
            run_insn("mov", {6'b100010, r[1:0]}, r[15:8], 8'h00);
            run_insn("mov_sreg", r[2] ? 8'h8E : 8'h8C, r[23:16], 8'h00);
            run_insn("alu", alu_base[i % 3] | {6'd0, r[4:3]}, r[31:24], 8'h00);
            run_insn("alu_imm", imm_ops[i % 3], r[23:16], 8'h00);
        end
    endtask

    task automatic test_escape();
        logic [31:0] r;
        insn_byte_t  movx_ops [4];
        movx_ops = '{8'hB6, 8'hB7, 8'hBE, 8'hBF};
        foreach (movx_ops[i]) begin
            r = $urandom;
            run_insn("movx", 8'h0F, movx_ops[i], r[7:0]);
        end
        run_insn("escape_illegal", 8'h0F, 8'h05, 8'h00);
        run_insn("escape_illegal", 8'h0F, 8'hAF, 8'h00);
    endtask

    task automatic random_insn(output insn_byte_t b0, output insn_byte_t b1,
                               output insn_byte_t b2);
        logic [31:0] r;
        insn_byte_t  illegal_ops [4];
        illegal_ops = '{8'h90, 8'hC3, 8'hF4, 8'h27};
        r  = $urandom;
        b1 = r[15:8];
        b2 = r[23:16];
        case (r[31:28])
            4'd0:    b0 = {6'b100010, r[1:0]};
            4'd1:    b0 = r[0] ? 8'h8E : 8'h8C;
            4'd2:    b0 = {4'hB, r[3:0]};
            4'd3:    b0 = {3'b010, r[4:0]};
            4'd4:    b0 = {3'b000, r[1:0], 3'b110};
            4'd5:    b0 = (r[1:0] == 2'b01) ? 8'h07 : {3'b000, r[1:0], 3'b111};  // skip 0f.
            4'd6:    b0 = {6'b000000, r[1:0]};
            4'd7:    b0 = r[2] ? {6'b001100, r[1:0]} : {6'b001010, r[1:0]};
            4'd8:    b0 = r[1] ? 8'h83 : {7'b1000000, r[0]};
            4'd9, 4'd10: begin
                b0 = 8'h0F;
                b1 = {4'hB, r[9], 2'b11, r[8]};
            end
            4'd11:   b0 = 8'h0F;
            default: b0 = illegal_ops[r[1:0]];
        endcase
    endtask

    task automatic test_stream();
        localparam int N = 200;
        insn_byte_t b [3];
        int         len;
        int         gap;
        int         received;
        int         idle;
        expected_q.delete();
        received = 0;
        idle     = 0;
        fork
            begin
                for (int n = 0; n < N; n++) begin
                    random_insn(b[0], b[1], b[2]);
                    len = insn_length(b[0], b[1]);
                    for (int i = 0; i < len; i++) begin
                        byte_valid = 1'b1;
                        byte_data  = b[i];
                        if (i == len - 1) expected_q.push_back(model_fields(b[0], b[1], b[2]));
                        @(negedge clk);
                        gap = $urandom_range(3, 0);  // zero keeps bytes back to back.
                        if (gap > 0) begin
                            byte_valid = 1'b0;
                            repeat (gap) @(negedge clk);
                        end
                    end
                end
                byte_valid = 1'b0;
            end
            while (received < N) begin
                @(negedge clk);
                if (fields_valid) begin
                    assert (expected_q.size() > 0) else begin
                        $display("stream: fields_valid pulse with no instruction outstanding");
                        $display("Test failed");
                        $fatal(1);
                    end
                    check_result("stream", expected_q.pop_front());
                    received++;
                    idle = 0;
                end else if (idle >= 20) begin
                    fail_timeout("stream");
                end else begin
                    idle++;
                end
            end
        join
        repeat (5) begin
            @(negedge clk);
            check_field("stream", "fields_valid after last result", 0, int'(fields_valid));
        end
    endtask

    initial begin
        rst        = 1'b1;
        byte_valid = 1'b0;
        byte_data  = 8'h00;
        void'($urandom(14275));
        test_reset();
        test_one_byte();
        test_modrm();
        test_escape();
        test_stream();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
src/decode_pkg.sv
src/insn_if.sv
src/decode_if.sv
src/insn_buffer.sv
src/opcode_classifier.sv
src/decode_sequencer.sv
src/field_extractor.sv
src/decode_field_top.sv
testbench/tb_decode_field.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the field decoder testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_decode_field \
    --Mdir obj_dir -o tb_decode_field
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_decode_field > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation passed"
exit 0
